/* logic/core_pkg.sv */
/* widths, RV32I encodings, enums and stage packets shared by the in-order core
   every core module pulls these in with a wildcard import */
`default_nettype none

package core_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;

    // fetch address sequence
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam logic [xlen-1:0] pc_step  = 32'd4;

    ////////////////////
    // encodings
    ////////////////////
    // major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_system = 7'b1110011;

    // funct3 of the supported alu ops
    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or  = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;

    // funct7, alt selects sub
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    // wfi is one fixed word under the system opcode
    localparam logic [31:0] wfi_word = 32'h1050_0073;

    ////////////////////
    // enums
    ////////////////////
    typedef enum logic [1:0] {op_alu, op_halt, op_illegal} op_kind_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_pass_b
    } alu_func_t;

    typedef enum logic [1:0] {no_error, halted_on_wfi, illegal_inst} error_status_t;

    ////////////////////
    // stage packets
    ////////////////////
    // fetch to decode
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } fetch_packet_t;

    // decode to execute, operands already read
    typedef struct packed {
        logic                 valid;
        op_kind_t             kind;
        alu_func_t            alu_func;
        logic [xlen-1:0]      opa;
        logic [xlen-1:0]      opb;
        logic [reg_idx_w-1:0] dest;
        logic                 has_dest;
        logic [xlen-1:0]      npc;
    } issue_packet_t;

    // execute to retire
    typedef struct packed {
        logic                 valid;
        op_kind_t             kind;
        logic [reg_idx_w-1:0] dest;
        logic                 has_dest;
        logic [xlen-1:0]      value;
        logic [xlen-1:0]      npc;
    } result_packet_t;

endpackage

`default_nettype wire

/* logic/register_file.sv */
/* architectural register file, two combinational reads and one write port
   x0 always reads as zero */
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [core_pkg::reg_idx_w-1:0]   rs1_idx,
    input  logic [core_pkg::reg_idx_w-1:0]   rs2_idx,
    output logic [core_pkg::xlen-1:0]        rs1_value,
    output logic [core_pkg::xlen-1:0]        rs2_value,
    input  logic                             wr_en,
    input  logic [core_pkg::reg_idx_w-1:0]   wr_idx,
    input  logic [core_pkg::xlen-1:0]        wr_data
);
    import core_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    // read ports, x0 forced
    assign rs1_value = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_value = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clock) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // decode never marks x0 as a destination
    assert property (@(posedge clock) disable iff (reset) wr_en |-> wr_idx != '0);

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
/* instruction fetch: pc, four-phase req/ack handshake to memory and the fetch packet
   decode consumes the packet with a one-cycle fetch_taken pulse */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                        clock,
    input  logic                        reset,
    output logic                        fetch_req,
    output logic [core_pkg::xlen-1:0]   fetch_addr,
    input  logic                        fetch_ack,
    input  logic [31:0]                 fetch_data,
    input  logic                        fetch_taken,
    output core_pkg::fetch_packet_t     fetch_packet
);
    import core_pkg::*;

    typedef enum logic [1:0] {fetch_idle, fetch_wait_ack, fetch_wait_release} fetch_state_t;

    fetch_state_t    state;
    fetch_state_t    state_next;
    logic [xlen-1:0] pc;
    logic            can_request;
    logic            capture;

    // new request only with ack low and room in the packet register
    assign can_request = !fetch_ack && (!fetch_packet.valid || fetch_taken);
    assign capture     = (state == fetch_wait_ack) && fetch_ack;

    // req follows the state flop, addr held by pc
    assign fetch_req  = (state == fetch_wait_ack);
    assign fetch_addr = pc;

    ////////////////////
    // handshake fsm
    ////////////////////
    always_comb begin
        state_next = state;
        case (state)
            fetch_idle: begin
                if (can_request) begin
                    state_next = fetch_wait_ack;
                end
            end
            // word arrives, drop req next cycle
            fetch_wait_ack: begin
                if (fetch_ack) begin
                    state_next = fetch_wait_release;
                end
            end
            // wait for memory to lower ack
            fetch_wait_release: begin
                if (can_request) begin
                    state_next = fetch_wait_ack;
                end else if (!fetch_ack) begin
                    state_next = fetch_idle;
                end
            end
            default: state_next = fetch_idle;
        endcase
    end

    ////////////////////
    // pc and packet
    ////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state              <= fetch_idle;
            pc                 <= reset_pc;
            fetch_packet.valid <= 1'b0;
        end else begin
            state <= state_next;
            // packet is always empty while waiting on ack
            if (capture) begin
                pc                 <= pc + pc_step;
                fetch_packet.valid <= 1'b1;
                fetch_packet.pc    <= pc;
                fetch_packet.inst  <= fetch_data;
            end else if (fetch_taken) begin
                fetch_packet.valid <= 1'b0;
            end
        end
    end

    // with ack still high from memory, req may not rise
    assert property (@(posedge clock) disable iff (reset)
        fetch_ack && !fetch_req |=> !fetch_req);

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
/* decode and dispatch: field decode, operand select, busy-bit hazard stall
   registers one issue packet per cycle toward execute */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                             clock,
    input  logic                             reset,
    input  core_pkg::fetch_packet_t          fetch_packet,
    output logic                             fetch_taken,
    output logic [core_pkg::reg_idx_w-1:0]   rs1_idx,
    output logic [core_pkg::reg_idx_w-1:0]   rs2_idx,
    input  logic [core_pkg::xlen-1:0]        rs1_value,
    input  logic [core_pkg::xlen-1:0]        rs2_value,
    input  logic                             wr_en,
    input  logic [core_pkg::reg_idx_w-1:0]   wr_idx,
    output core_pkg::issue_packet_t          issue_packet
);
    import core_pkg::*;

    logic [31:0]          inst;
    logic [6:0]           opcode;
    logic [6:0]           funct7;
    logic [2:0]           funct3;
    logic [reg_idx_w-1:0] rd;
    op_kind_t             kind;
    alu_func_t            alu_func;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 use_imm;
    logic [xlen-1:0]      imm;
    logic                 has_dest;
    logic [reg_count-1:0] busy;
    logic                 stopped;
    logic                 hazard;

    // instruction fields
    assign inst    = fetch_packet.inst;
    assign opcode  = inst[6:0];
    assign rd      = inst[11:7];
    assign funct3  = inst[14:12];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];
    assign funct7  = inst[31:25];

    ////////////////////
    // decode
    ////////////////////
    always_comb begin
        kind     = op_illegal;
        alu_func = alu_add;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        use_imm  = 1'b0;
        imm      = {{20{inst[31]}}, inst[31:20]};
        case (opcode)
            // register-register
            opcode_op: begin
                kind     = op_alu;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case ({funct7, funct3})
                    {funct7_base, funct3_add}: alu_func = alu_add;
                    {funct7_alt, funct3_add}:  alu_func = alu_sub;
                    {funct7_base, funct3_xor}: alu_func = alu_xor;
                    {funct7_base, funct3_or}:  alu_func = alu_or;
                    {funct7_base, funct3_and}: alu_func = alu_and;
                    default:                   kind = op_illegal;
                endcase
            end
            // immediate forms, shifts and compares are not supported
            opcode_op_imm: begin
                kind     = op_alu;
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                case (funct3)
                    funct3_add: alu_func = alu_add;
                    funct3_xor: alu_func = alu_xor;
                    funct3_or:  alu_func = alu_or;
                    funct3_and: alu_func = alu_and;
                    default:    kind = op_illegal;
                endcase
            end
            // upper immediate straight through the alu
            opcode_lui: begin
                kind     = op_alu;
                alu_func = alu_pass_b;
                use_imm  = 1'b1;
                imm      = {inst[31:12], 12'b0};
            end
            opcode_system: begin
                if (inst == wfi_word) begin
                    kind = op_halt;
                end
            end
            default: kind = op_illegal;
        endcase
        // halt and illegal read nothing, so never stall
        if (kind != op_alu) begin
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end
    end

    // x0 writes are dropped here
    assign has_dest = (kind == op_alu) && (rd != '0);

    // pending writer on a source, or on the dest itself
    assign hazard = (uses_rs1 && busy[rs1_idx]) || (uses_rs2 && busy[rs2_idx])
                 || (has_dest && busy[rd]);

    assign fetch_taken = fetch_packet.valid && !stopped && !hazard;

    ////////////////////
    // busy bits and dispatch
    ////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy               <= '0;
            stopped            <= 1'b0;
            issue_packet.valid <= 1'b0;
        end else begin
            // clear at retire, a same-edge dispatch set wins
            if (wr_en) begin
                busy[wr_idx] <= 1'b0;
            end
            if (fetch_taken && has_dest) begin
                busy[rd] <= 1'b1;
            end
            // halt or illegal closes the front end for good
            if (fetch_taken && kind != op_alu) begin
                stopped <= 1'b1;
            end
            issue_packet.valid <= fetch_taken;
            if (fetch_taken) begin
                issue_packet.kind     <= kind;
                issue_packet.alu_func <= alu_func;
                issue_packet.opa      <= rs1_value;
                issue_packet.opb      <= use_imm ? imm : rs2_value;
                issue_packet.dest     <= rd;
                issue_packet.has_dest <= has_dest;
                issue_packet.npc      <= fetch_packet.pc + pc_step;
            end
        end
    end

    // a source being dispatched has no writer still in flight down the pipe
    assert property (@(posedge clock) disable iff (reset)
        fetch_taken && wr_en |->
            !(uses_rs1 && wr_idx == rs1_idx) && !(uses_rs2 && wr_idx == rs2_idx));

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
/* single-cycle ALU and the execute-to-retire register
   accepts an issue packet every cycle */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  core_pkg::issue_packet_t  issue_packet,
    output core_pkg::result_packet_t result_packet
);
    import core_pkg::*;

    logic [xlen-1:0] alu_result;

    ////////////////////
    // alu
    ////////////////////
    always_comb begin
        case (issue_packet.alu_func)
            alu_add:    alu_result = issue_packet.opa + issue_packet.opb;
            alu_sub:    alu_result = issue_packet.opa - issue_packet.opb;
            alu_and:    alu_result = issue_packet.opa & issue_packet.opb;
            alu_or:     alu_result = issue_packet.opa | issue_packet.opb;
            alu_xor:    alu_result = issue_packet.opa ^ issue_packet.opb;
            // lui immediate
            alu_pass_b: alu_result = issue_packet.opb;
            default:    alu_result = '0;
        endcase
    end

    // result register, payload only moves with a valid item
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_packet.valid <= 1'b0;
        end else begin
            result_packet.valid <= issue_packet.valid;
            if (issue_packet.valid) begin
                result_packet.kind     <= issue_packet.kind;
                result_packet.dest     <= issue_packet.dest;
                result_packet.has_dest <= issue_packet.has_dest;
                result_packet.value    <= alu_result;
                result_packet.npc      <= issue_packet.npc;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/retire_stage.sv */
/* retire: register-file write, registered commit report and sticky error status
   halt and illegal items set the status and commit nothing */
`timescale 1ns/1ns
`default_nettype none

module retire_stage (
    input  logic                             clock,
    input  logic                             reset,
    input  core_pkg::result_packet_t         result_packet,
    output logic                             wr_en,
    output logic [core_pkg::reg_idx_w-1:0]   wr_idx,
    output logic [core_pkg::xlen-1:0]        wr_data,
    output logic                             commit_valid,
    output logic                             commit_has_dest,
    output logic [core_pkg::reg_idx_w-1:0]   commit_idx,
    output logic [core_pkg::xlen-1:0]        commit_data,
    output logic [core_pkg::xlen-1:0]        commit_npc,
    output core_pkg::error_status_t          error_status
);
    import core_pkg::*;

    logic retire_alu;

    assign retire_alu = result_packet.valid && (result_packet.kind == op_alu);

    // write lands on the same edge as the commit report
    assign wr_en   = retire_alu && result_packet.has_dest;
    assign wr_idx  = result_packet.dest;
    assign wr_data = result_packet.value;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            commit_valid <= 1'b0;
            error_status <= no_error;
        end else begin
            commit_valid <= retire_alu;
            if (retire_alu) begin
                commit_has_dest <= result_packet.has_dest;
                commit_idx      <= result_packet.dest;
                commit_data     <= result_packet.value;
                commit_npc      <= result_packet.npc;
            end
            // first stop reason sticks
            if (result_packet.valid && error_status == no_error) begin
                if (result_packet.kind == op_halt) begin
                    error_status <= halted_on_wfi;
                end else if (result_packet.kind == op_illegal) begin
                    error_status <= illegal_inst;
                end
            end
        end
    end

    // decode stops after a halt or illegal item, so nothing retires behind it
    assert property (@(posedge clock) disable iff (reset)
        error_status != no_error |-> !commit_valid);

endmodule

`default_nettype wire

/* logic/core_pipeline.sv */
/* top of the in-order core: fetch, decode, execute and retire around the register file
   memory sits outside on the four-phase fetch port */
`timescale 1ns/1ns
`default_nettype none

module core_pipeline (
    input  logic                             clock,
    input  logic                             reset,
    output logic                             fetch_req,
    output logic [core_pkg::xlen-1:0]        fetch_addr,
    input  logic                             fetch_ack,
    input  logic [31:0]                      fetch_data,
    output logic                             commit_valid,
    output logic                             commit_has_dest,
    output logic [core_pkg::reg_idx_w-1:0]   commit_idx,
    output logic [core_pkg::xlen-1:0]        commit_data,
    output logic [core_pkg::xlen-1:0]        commit_npc,
    output core_pkg::error_status_t          error_status
);
    import core_pkg::*;

    ////////////////////
    // stage links
    ////////////////////
    fetch_packet_t        fetch_packet;
    logic                 fetch_taken;
    issue_packet_t        issue_packet;
    result_packet_t       result_packet;

    // register file ports
    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;
    logic [xlen-1:0]      rs1_value;
    logic [xlen-1:0]      rs2_value;

    // retire write, also clears decode busy bits
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_idx;
    logic [xlen-1:0]      wr_data;

    fetch_stage fetch_stage_inst (
        .clock        (clock),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_ack    (fetch_ack),
        .fetch_data   (fetch_data),
        .fetch_taken  (fetch_taken),
        .fetch_packet (fetch_packet)
    );

    decode_stage decode_stage_inst (
        .clock        (clock),
        .reset        (reset),
        .fetch_packet (fetch_packet),
        .fetch_taken  (fetch_taken),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .issue_packet (issue_packet)
    );

    register_file register_file_inst (
        .clock     (clock),
        .reset     (reset),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    execute_stage execute_stage_inst (
        .clock         (clock),
        .reset         (reset),
        .issue_packet  (issue_packet),
        .result_packet (result_packet)
    );

    retire_stage retire_stage_inst (
        .clock           (clock),
        .reset           (reset),
        .result_packet   (result_packet),
        .wr_en           (wr_en),
        .wr_idx          (wr_idx),
        .wr_data         (wr_data),
        .commit_valid    (commit_valid),
        .commit_has_dest (commit_has_dest),
        .commit_idx      (commit_idx),
        .commit_data     (commit_data),
        .commit_npc      (commit_npc),
        .error_status    (error_status)
    );

endmodule

`default_nettype wire

/* include/ref_model.svh */
/* instruction-level model of the core, included inside the testbench module
   holds the program image, the model registers and the expected commit queue */
`ifndef ref_model_svh
`define ref_model_svh

// random legal instructions ahead of the final word
localparam int prog_len = 60;

// one expected commit
typedef struct packed {
    logic                 has_dest;
    logic [reg_idx_w-1:0] idx;
    logic [xlen-1:0]      data;
    logic [xlen-1:0]      npc;
} commit_entry_t;

logic [31:0]     program_mem [prog_len+1];
logic [xlen-1:0] model_regs [reg_count];
commit_entry_t   expected_q [$];

// one instruction, rv32i rules for the supported subset
function automatic void model_step(input logic [31:0] word, input logic [xlen-1:0] pc);
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;
    commit_entry_t   entry;
    rd  = word[11:7];
    rs1 = word[19:15];
    rs2 = word[24:20];
    a   = model_regs[rs1];
    // rs2 for register ops, sign-extended imm otherwise
    b   = (word[6:0] == opcode_op) ? model_regs[rs2] : {{20{word[31]}}, word[31:20]};
    if (word[6:0] == opcode_lui) begin
        result = {word[31:12], 12'h000};
    end else begin
        case (word[14:12])
            // bit 30 picks sub, register form only
            3'b000:  result = (word[6:0] == opcode_op && word[30]) ? a - b : a + b;
            3'b100:  result = a ^ b;
            3'b110:  result = a | b;
            3'b111:  result = a & b;
            default: result = '0;
        endcase
    end
    // x0 never written
    if (rd != 5'd0) begin
        model_regs[rd] = result;
    end
    entry.has_dest = (rd != 5'd0);
    entry.idx      = rd;
    entry.data     = result;
    entry.npc      = pc + pc_step;
    expected_q.push_back(entry);
endfunction

// whole program, the final word commits nothing
function automatic void model_run();
    logic [5:0]      slot;
    logic [xlen-1:0] pc;
    expected_q.delete();
    for (slot = 6'd0; slot < 6'd32; slot++) begin
        model_regs[slot[4:0]] = '0;
    end
    pc = reset_pc;
    for (slot = 6'd0; slot < 6'(prog_len); slot++) begin
        model_step(program_mem[slot], pc);
        pc = pc + pc_step;
    end
endfunction

`endif

/* tb/core_tb.sv */
/* testbench for the in-order core: random programs, a fetch memory responder
   and commit checks against the included reference model */
`timescale 1ns/1ns
`default_nettype none

module core_tb;
    import core_pkg::*;

    logic                 clock = 1'b0;
    logic                 reset = 1'b1;
    logic                 fetch_req;
    logic [xlen-1:0]      fetch_addr;
    logic                 fetch_ack = 1'b0;
    logic [31:0]          fetch_data = '0;
    logic                 commit_valid;
    logic                 commit_has_dest;
    logic [reg_idx_w-1:0] commit_idx;
    logic [xlen-1:0]      commit_data;
    logic [xlen-1:0]      commit_npc;
    error_status_t        error_status;

    `include "ref_model.svh"

    localparam int reset_cycles = 4;
    // pipeline depth plus slack, long enough to catch a stray commit
    localparam int drain_cycles = 8;
    // two runs, 61 words each, 12 cycles a word, plus resets and drains
    localparam int timeout_cycles = 2 * (prog_len + 1) * 12
                                  + 2 * (reset_cycles + drain_cycles + 2);
    // final word plus at most one fetch past it
    localparam logic [xlen-1:0] last_fetch_addr = reset_pc + pc_step * (prog_len + 1);

    integer          seed;
    string           test_name;
    int              mismatch_count = 0;
    int              failure_count = 0;
    int              commit_count = 0;
    int              cycle_count = 0;
    // responder state
    int              ack_delay = 0;
    logic            ack_armed = 1'b0;
    logic            last_req = 1'b0;
    logic [xlen-1:0] req_addr = '0;
    logic [xlen-1:0] expected_addr = '0;

    core_pipeline core_pipeline_inst (
        .clock           (clock),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_addr      (fetch_addr),
        .fetch_ack       (fetch_ack),
        .fetch_data      (fetch_data),
        .commit_valid    (commit_valid),
        .commit_has_dest (commit_has_dest),
        .commit_idx      (commit_idx),
        .commit_data     (commit_data),
        .commit_npc      (commit_npc),
        .error_status    (error_status)
    );

    // 4 ns period
    always #2 clock = ~clock;

    ////////////////////
    // helpers
    ////////////////////
    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("mismatch %s %s: expected %h actual %h", test_name, field, expected, actual);
        end
    endtask

    // random legal word, registers x0 to x5 only so hazards come often
    function automatic logic [31:0] random_inst(input logic [5:0] slot);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        int          pick;
        logic [31:0] inst;
        rd    = 5'($unsigned($random(seed)) % 6);
        rs1   = 5'($unsigned($random(seed)) % 6);
        rs2   = 5'($unsigned($random(seed)) % 6);
        imm   = 12'($random(seed));
        upper = 20'($random(seed));
        pick  = int'($unsigned($random(seed)) % 10);
        // register file has no reset, so x1..x5 get written first
        if (slot < 6'd5) begin
            rd   = 5'(slot + 6'd1);
            rs1  = 5'd0;
            pick = (pick < 5) ? 5 : 9;
        end
        case (pick)
            0:       inst = {7'b0000000, rs2, rs1, 3'b000, rd, opcode_op};
            1:       inst = {7'b0100000, rs2, rs1, 3'b000, rd, opcode_op};
            2:       inst = {7'b0000000, rs2, rs1, 3'b111, rd, opcode_op};
            3:       inst = {7'b0000000, rs2, rs1, 3'b110, rd, opcode_op};
            4:       inst = {7'b0000000, rs2, rs1, 3'b100, rd, opcode_op};
            5:       inst = {imm, rs1, 3'b000, rd, opcode_op_imm};
            6:       inst = {imm, rs1, 3'b100, rd, opcode_op_imm};
            7:       inst = {imm, rs1, 3'b110, rd, opcode_op_imm};
            8:       inst = {imm, rs1, 3'b111, rd, opcode_op_imm};
            default: inst = {upper, rd, opcode_lui};
        endcase
        return inst;
    endfunction

    // outside the program the word is a pattern of the address
    function automatic logic [31:0] memory_word(input logic [xlen-1:0] addr);
        logic [xlen-1:0] index;
        index = addr >> 2;
        if (index <= prog_len) begin
            return program_mem[index[5:0]];
        end
        return ~addr;
    endfunction

    ////////////////////
    // fetch responder
    ////////////////////
    always @(posedge clock) begin
        #1;
        if (reset) begin
            fetch_ack     = 1'b0;
            ack_armed     = 1'b0;
            last_req      = 1'b0;
            expected_addr = reset_pc;
        end else begin
            // req rises only against a low ack, then addr holds
            if (fetch_req && !last_req) begin
                assert (!fetch_ack) else begin
                    failure_count++;
                    $display("%s: fetch request rose while ack was still high", test_name);
                end
                req_addr = fetch_addr;
            end else if (fetch_req) begin
                assert (fetch_addr == req_addr) else begin
                    failure_count++;
                    $display("%s: fetch address changed while request was high", test_name);
                end
            end
            last_req = fetch_req;
            if (fetch_ack) begin
                // release once req has dropped
                if (!fetch_req) begin
                    fetch_ack = 1'b0;
                end
            end else if (fetch_req) begin
                if (!ack_armed) begin
                    ack_delay = $unsigned($random(seed)) % 4;
                    ack_armed = 1'b1;
                end
                if (ack_delay == 0) begin
                    check_value("fetch_addr", expected_addr, fetch_addr);
                    assert (fetch_addr <= last_fetch_addr) else begin
                        failure_count++;
                        $display("%s: fetch ran more than one word past the end", test_name);
                    end
                    fetch_data    = memory_word(fetch_addr);
                    fetch_ack     = 1'b1;
                    ack_armed     = 1'b0;
                    expected_addr = expected_addr + pc_step;
                end else begin
                    ack_delay = ack_delay - 1;
                end
            end
        end
    end

    ////////////////////
    // commit checker
    ////////////////////
    always @(posedge clock) begin
        commit_entry_t entry;
        #1;
        if (reset) begin
            commit_count = 0;
        end else if (commit_valid) begin
            commit_count++;
            assert (error_status == no_error) else begin
                failure_count++;
                $display("%s: commit seen after the core had stopped", test_name);
            end
            assert (expected_q.size() != 0) else begin
                failure_count++;
                $display("%s: commit with no expected entry left", test_name);
            end
            if (expected_q.size() != 0) begin
                entry = expected_q.pop_front();
                check_value("commit_has_dest", 32'(entry.has_dest), 32'(commit_has_dest));
                check_value("commit_idx", 32'(entry.idx), 32'(commit_idx));
                check_value("commit_data", entry.data, commit_data);
                check_value("commit_npc", entry.npc, commit_npc);
            end
        end
    end

    // hang guard over both runs
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout after %0d cycles, %s never stopped", cycle_count, test_name);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                     failure_count);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////
    // runs
    ////////////////////
    task automatic run_program(input string name, input logic [31:0] final_word,
                               input error_status_t final_status);
        logic [5:0] slot;
        test_name = name;
        for (slot = 6'd0; slot < 6'(prog_len); slot++) begin
            program_mem[slot] = random_inst(slot);
        end
        program_mem[6'(prog_len)] = final_word;
        model_run();
        @(posedge clock);
        #1;
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        // wait for halt or illegal to reach retire
        do begin
            @(posedge clock);
            #1;
        end while (error_status == no_error);
        repeat (drain_cycles) @(posedge clock);
        #1;
        assert (error_status == final_status) else begin
            mismatch_count++;
            $display("mismatch %s error_status: expected %s actual %s", test_name,
                     final_status.name(), error_status.name());
        end
        check_value("commit_count", prog_len, commit_count);
        assert (expected_q.size() == 0) else begin
            failure_count++;
            $display("%s: %0d expected commits never arrived", test_name, expected_q.size());
        end
    endtask

    initial begin
        logic [31:0] bad_word;
        seed = 32'h91b2f54d;
        run_program("run_a", wfi_word, halted_on_wfi);
        // load opcode, outside the supported subset
        bad_word      = $random(seed);
        bad_word[6:0] = 7'b0000011;
        run_program("run_b", bad_word, illegal_inst);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
logic/core_pkg.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/core_pipeline.sv
tb/core_tb.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

# build the simulator from the file list
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
